//--- tb.f
hdl/cd_bus_pkg.sv
hdl/cd_regs_pkg.sv
hdl/cd_link_if.sv
hdl/cdc_regs.sv
hdl/scsi_target.sv
hdl/sector_reader.sv
hdl/pcecd_top.sv
sim/tb_pcecd.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pcecd \
	-f tb.f --Mdir obj_dir -o tb_pcecd_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_pcecd_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

//--- sim/tb_pcecd.sv
module tb_pcecd
	import cd_bus_pkg::*, cd_regs_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SECTOR_BYTES = 16;
	localparam int BUF_BYTES    = 256;
	localparam int WAIT_LIMIT   = 4000;  // Polls before giving up

	logic        CLOCK;
	logic        RESET;
	logic        CS_N;
	logic        RD_N;
	logic        WR_N;
	cd_byte_t    ADDR;
	cd_byte_t    DIN;
	cd_byte_t    DOUT;
	logic        IRQ2_ASSERT;
	cd_lba_t     sd_lba;
	logic        sd_rd;
	logic        sd_ack;
	logic [15:0] sd_buff_din;
	logic        sd_buff_wr;

	integer   seed;
	int       errors;
	int       checks;
	int       tests;
	int       errs_at_start;
	cd_byte_t mask_val;              // Interrupt mask kept under ACK writes
	cd_byte_t exp_data [BUF_BYTES];  // Bytes the host model sent

	pcecd_top #(
		.SECTOR_BYTES (SECTOR_BYTES),
		.BUF_BYTES    (BUF_BYTES)
	) i_pcecd_top (
		.CLOCK       (CLOCK),
		.RESET       (RESET),
		.CS_N        (CS_N),
		.RD_N        (RD_N),
		.WR_N        (WR_N),
		.ADDR        (ADDR),
		.DIN         (DIN),
		.DOUT        (DOUT),
		.IRQ2_ASSERT (IRQ2_ASSERT),
		.sd_lba      (sd_lba),
		.sd_rd       (sd_rd),
		.sd_ack      (sd_ack),
		.sd_buff_din (sd_buff_din),
		.sd_buff_wr  (sd_buff_wr)
	);

	// 40 ns period
	always begin
		CLOCK = 1'b0;
		#20;
		CLOCK = 1'b1;
		#20;
	end

	// Land 2 ns past the rising edge
	task automatic tick(input int n);
		repeat (n) @(posedge CLOCK);
		#2;
	endtask

	task automatic abort_run(input string what);
		$display("Timed out waiting for %s at %0t ns", what, $time);
		$display("Regression failed");
		$finish;
	endtask

	task automatic check_byte(input cd_byte_t got, input cd_byte_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_lba(input cd_lba_t got, input cd_lba_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Strobe acts on the third of five low cycles
	task automatic cpu_write(input cd_byte_t addr, input cd_byte_t data);
		ADDR = addr;
		DIN  = data;
		CS_N = 1'b0;
		WR_N = 1'b0;
		tick(5);
		WR_N = 1'b1;
		CS_N = 1'b1;
		tick(2);
	endtask

	task automatic cpu_read(input cd_byte_t addr, output cd_byte_t data);
		ADDR = addr;
		CS_N = 1'b0;
		RD_N = 1'b0;
		#10;
		data = DOUT;  // DOUT settled by mid cycle
		tick(1);
		RD_N = 1'b1;
		CS_N = 1'b1;
	endtask

	// Poll CDC_STAT until the masked bits match
	task automatic wait_stat(input cd_byte_t want, input cd_byte_t care, input string what);
		cd_byte_t stat;
		int       n;
		n = 0;
		cpu_read(CDC_STAT, stat);
		while ((stat & care) !== (want & care)) begin
			if (n == WAIT_LIMIT)
				abort_run(what);
			n++;
			cpu_read(CDC_STAT, stat);
		end
	endtask

	task automatic send_byte(input cd_byte_t b);
		wait_stat(8'h40, 8'h40, "REQ for a command byte");
		cpu_write(CDC_CMD, b);
		cpu_write(INT_MASK, mask_val | 8'h80);           // ACK up
		wait_stat(8'h00, 8'h40, "REQ to drop under ACK");
		cpu_write(INT_MASK, mask_val);                   // ACK down
	endtask

	task automatic recv_byte(output cd_byte_t b);
		wait_stat(8'h40, 8'h40, "REQ for an incoming byte");
		cpu_read(CDC_CMD, b);
		cpu_write(INT_MASK, mask_val | 8'h80);
		wait_stat(8'h00, 8'h40, "REQ to drop under ACK");
		cpu_write(INT_MASK, mask_val);
	endtask

	// Host storage model serving one sector per sd_rd request
	task automatic serve_sectors(input cd_lba_t first, input int n);
		logic [15:0] word;
		int          s;
		int          w;
		int          cnt;
		for (s = 0; s < n; s++) begin
			cnt = 0;
			while (sd_rd !== 1'b1) begin
				if (cnt == WAIT_LIMIT)
					abort_run("sd_rd from the sector reader");
				cnt++;
				tick(1);
			end
			check_lba(sd_lba, cd_lba_t'(first + s), "sd_lba");
			sd_ack = 1'b1;
			tick(1);
			for (w = 0; w < SECTOR_BYTES / 2; w++) begin
				word = 16'($random(seed));
				exp_data[s * SECTOR_BYTES + 2 * w]     = word[7:0];   // Low byte even
				exp_data[s * SECTOR_BYTES + 2 * w + 1] = word[15:8];
				sd_buff_din = word;
				sd_buff_wr  = 1'b1;
				tick(1);
			end
			sd_buff_wr = 1'b0;
			tick(1);
			sd_ack = 1'b0;  // Sector end
			tick(1);
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == errs_at_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d check(s) wrong", name, errors - errs_at_start);
		errs_at_start = errors;
	endtask

	task automatic test_reset_state();
		cd_byte_t v;
		cd_byte_t id_exp [7];
		int       i;
		id_exp = '{8'hAA, 8'h55, 8'h00, 8'hFF, 8'hAA, 8'h55, 8'h03};
		cpu_read(CD_RESET, v);
		check_byte(v, 8'h02, "CD_RESET");  // Drive held in reset
		cpu_read(CDC_STAT, v);
		check_byte(v, 8'h00, "CDC_STAT");
		for (i = 0; i < 7; i++) begin
			cpu_read(cd_byte_t'(8'hC1 + i), v);
			check_byte(v, id_exp[i], "identification byte");
		end
		cpu_read(8'h10, v);
		check_byte(v, 8'hFF, "unmapped register");
		check_bit(IRQ2_ASSERT, 1'b0, "IRQ2_ASSERT");
		check_bit(sd_rd, 1'b0, "sd_rd");
	endtask

	task automatic test_selection();
		cd_byte_t v;
		mask_val = 8'h00;
		cpu_write(CD_RESET, 8'h00);
		cpu_write(CDC_STAT, 8'h81);
		cpu_read(CDC_STAT, v);
		check_byte(v, 8'hD1, "CDC_STAT after select");  // BSY REQ CD plus ID
		cpu_write(CDC_CMD, 8'h81);
		cpu_read(CDC_STAT, v);
		check_byte(v, 8'h00, "CDC_STAT after deselect");
	endtask

	task automatic test_unit_ready();
		cd_byte_t v;
		cd_byte_t pkt [6];
		int       i;
		pkt = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hC0};  // Vendor bits in the control byte
		mask_val = 8'h00;
		cpu_write(CDC_STAT, 8'h81);
		for (i = 0; i < 6; i++)
			send_byte(pkt[i]);
		wait_stat(8'hD9, 8'hFF, "status phase");
		recv_byte(v);
		check_byte(v, 8'h00, "status byte");
		cpu_read(CDC_STAT, v);
		check_byte(v, 8'hF9, "CDC_STAT in message-in");
		recv_byte(v);
		check_byte(v, 8'h00, "message byte");
		cpu_read(CDC_STAT, v);
		check_byte(v, 8'h00, "CDC_STAT after message");
	endtask

	task automatic test_read6();
		cd_byte_t v;
		cd_byte_t pkt [6];
		int       i;
		pkt = '{8'h08, 8'h01, 8'h23, 8'h45, 8'h03, 8'h00};  // LBA 0x012345 and 3 sectors
		mask_val = 8'h40;  // READY only
		cpu_write(INT_MASK, mask_val);
		cpu_write(CDC_STAT, 8'h81);
		for (i = 0; i < 6; i++)
			send_byte(pkt[i]);
		serve_sectors(32'h0001_2345, 3);
		wait_stat(8'hC9, 8'hFF, "data-in phase");
		check_bit(IRQ2_ASSERT, 1'b1, "IRQ2_ASSERT on READY");
		for (i = 0; i < 3 * SECTOR_BYTES; i++) begin
			recv_byte(v);
			check_byte(v, exp_data[i], "data byte");
		end
		wait_stat(8'hD9, 8'hFF, "status after data-in");
		cpu_read(IRQ_FLAGS, v);
		check_byte(v, 8'h20, "IRQ_FLAGS");  // DONE set and READY clear
		cpu_read(CDC_STAT, v);
		check_byte(v, 8'hD9, "CDC_STAT in status");
		check_bit(IRQ2_ASSERT, 1'b0, "IRQ2_ASSERT with READY clear");
		recv_byte(v);
		check_byte(v, 8'h00, "status byte");
		recv_byte(v);
		check_byte(v, 8'h00, "message byte");
	endtask

	task automatic test_nec_pause();
		cd_byte_t v;
		int       i;
		mask_val = 8'h20;  // DONE only
		cpu_write(INT_MASK, mask_val);
		cpu_write(CDC_STAT, 8'h81);
		send_byte(8'hDA);
		for (i = 1; i < 10; i++)
			send_byte(8'h00);
		wait_stat(8'hD9, 8'hFF, "status after NEC_PAUSE");
		check_bit(IRQ2_ASSERT, 1'b1, "IRQ2_ASSERT on DONE");
		cpu_read(CDC_STAT, v);
		check_byte(v, 8'hD9, "CDC_STAT in status");
		recv_byte(v);
		check_byte(v, 8'h00, "status byte");
		recv_byte(v);
		check_byte(v, 8'h00, "message byte");
		check_bit(IRQ2_ASSERT, 1'b0, "IRQ2_ASSERT after bus free");  // DONE cleared
	endtask

	task automatic test_drive_reset();
		cd_byte_t v;
		cd_byte_t pkt [6];
		int       i;
		pkt = '{8'h08, 8'h00, 8'h00, 8'h10, 8'h01, 8'h00};
		mask_val = 8'h40;
		cpu_write(INT_MASK, mask_val);
		cpu_write(CDC_STAT, 8'h81);
		for (i = 0; i < 6; i++)
			send_byte(pkt[i]);
		serve_sectors(32'h0000_0010, 1);
		wait_stat(8'hC9, 8'hFF, "data-in phase");
		for (i = 0; i < 2; i++) begin  // Stop part way through the sector
			recv_byte(v);
			check_byte(v, exp_data[i], "data byte");
		end
		cpu_write(CD_RESET, 8'h02);
		mask_val = 8'h00;  // Cleared by drive reset
		cpu_read(CDC_STAT, v);
		check_byte(v, 8'h00, "CDC_STAT in drive reset");
		check_bit(IRQ2_ASSERT, 1'b0, "IRQ2_ASSERT in drive reset");
		cpu_write(CDC_STAT, 8'h81);  // Ignored while held
		cpu_read(CDC_STAT, v);
		check_byte(v, 8'h00, "CDC_STAT after select in drive reset");
	endtask

	initial begin
		RESET       = 1'b1;
		CS_N        = 1'b1;
		RD_N        = 1'b1;
		WR_N        = 1'b1;
		ADDR        = '0;
		DIN         = '0;
		sd_ack      = 1'b0;
		sd_buff_din = '0;
		sd_buff_wr  = 1'b0;
		seed          = 11090;
		errors        = 0;
		checks        = 0;
		tests         = 0;
		errs_at_start = 0;
		mask_val      = '0;
		repeat (3) @(posedge CLOCK);
		#2;
		RESET = 1'b0;
		tick(1);

		test_reset_state();
		report_test("reset state");
		test_selection();
		report_test("selection");
		test_unit_ready();
		report_test("test unit ready");
		test_read6();
		report_test("read6");
		test_nec_pause();
		report_test("nec pause");
		test_drive_reset();
		report_test("drive reset");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- hdl/pcecd_top.sv
module pcecd_top
	import cd_bus_pkg::*, cd_regs_pkg::*;
#(
	parameter int SECTOR_BYTES = 2048,
	parameter int BUF_BYTES    = 16384  // Multiple of SECTOR_BYTES
) (
	input  logic        CLOCK,
	input  logic        RESET,
	// CPU side
	input  logic        CS_N,
	input  logic        RD_N,
	input  logic        WR_N,
	input  cd_byte_t    ADDR,
	input  cd_byte_t    DIN,
	output cd_byte_t    DOUT,
	output logic        IRQ2_ASSERT,
	// Host storage side
	output cd_lba_t     sd_lba,
	output logic        sd_rd,
	input  logic        sd_ack,
	input  logic [15:0] sd_buff_din,
	input  logic        sd_buff_wr
);
	cd_link_if link ();
	cd_fetch_if #(.BUF_BYTES(BUF_BYTES)) fetch ();

	cdc_regs i_cdc_regs (
		.CLOCK       (CLOCK),
		.RESET       (RESET),
		.CS_N        (CS_N),
		.RD_N        (RD_N),
		.WR_N        (WR_N),
		.ADDR        (ADDR),
		.DIN         (DIN),
		.DOUT        (DOUT),
		.IRQ2_ASSERT (IRQ2_ASSERT),
		.link        (link.regs)
	);

	scsi_target #(
		.SECTOR_BYTES (SECTOR_BYTES),
		.BUF_BYTES    (BUF_BYTES)
	) i_scsi_target (
		.CLOCK (CLOCK),
		.RESET (RESET),
		.link  (link.target),
		.fetch (fetch.ctrl)
	);

	sector_reader #(
		.SECTOR_BYTES (SECTOR_BYTES),
		.BUF_BYTES    (BUF_BYTES)
	) i_sector_reader (
		.CLOCK       (CLOCK),
		.RESET       (RESET),
		.sd_ack      (sd_ack),
		.sd_buff_wr  (sd_buff_wr),
		.sd_buff_din (sd_buff_din),
		.sd_lba      (sd_lba),
		.sd_rd       (sd_rd),
		.fetch       (fetch.reader)
	);

endmodule

//--- hdl/sector_reader.sv
module sector_reader
	import cd_bus_pkg::*, cd_regs_pkg::*;
#(
	parameter int SECTOR_BYTES = 2048,
	parameter int BUF_BYTES    = 16384
) (
	input  logic        CLOCK,
	input  logic        RESET,
	input  logic        sd_ack,
	input  logic        sd_buff_wr,
	input  logic [15:0] sd_buff_din,
	output cd_lba_t     sd_lba,
	output logic        sd_rd,
	cd_fetch_if.reader  fetch
);
	localparam int AW = $clog2(BUF_BYTES);
	localparam int WW = AW - 1;  // Word index
	localparam logic [WW-1:0] SECTOR_WORDS = WW'(SECTOR_BYTES / 2);

	typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_STORE, RD_NEXT} rd_state_e;

	rd_state_e     state;
	logic [7:0]    sectors_left;
	logic [WW-1:0] sec_base;   // First word of the current sector
	logic [WW-1:0] wr_word;
	logic          store;
	logic          hi_we;
	logic [WW-1:0] hi_word;
	cd_byte_t      hi_byte;
	cd_byte_t      mem_even [BUF_BYTES/2];
	cd_byte_t      mem_odd  [BUF_BYTES/2];
	cd_byte_t      even_q;
	cd_byte_t      odd_q;
	logic          odd_sel;

	// First word may arrive with sd_ack itself
	assign store = sd_buff_wr && sd_ack && (state != RD_IDLE);

	always_ff @(posedge CLOCK) begin
		if (store)
			mem_even[wr_word] <= sd_buff_din[7:0];  // Low byte, even address
		even_q <= mem_even[fetch.rd_pos[AW-1:1]];
	end

	always_ff @(posedge CLOCK) begin
		if (hi_we)
			mem_odd[hi_word] <= hi_byte;  // High byte, next cycle
		odd_q <= mem_odd[fetch.rd_pos[AW-1:1]];
	end

	always_ff @(posedge CLOCK) begin
		hi_byte <= sd_buff_din[15:8];
		hi_word <= wr_word;
		odd_sel <= fetch.rd_pos[0];
	end

	assign fetch.rd_data = odd_sel ? odd_q : even_q;

	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			state        <= RD_IDLE;
			sd_rd        <= 1'b0;
			sd_lba       <= '0;
			sectors_left <= '0;
			sec_base     <= '0;
			wr_word      <= '0;
			hi_we        <= 1'b0;
			fetch.loaded <= 1'b0;
		end else begin
			hi_we        <= store;
			fetch.loaded <= 1'b0;
			if (store)
				wr_word <= wr_word + 1'b1;
			case (state)
				RD_IDLE: if (fetch.start) begin
					sd_lba       <= fetch.first_lba;
					sectors_left <= fetch.count;
					sec_base     <= '0;
					wr_word      <= '0;
					sd_rd        <= 1'b1;
					state        <= RD_REQ;
				end
				RD_REQ: if (sd_ack) begin
					sd_rd <= 1'b0;  // Host has taken the request
					state <= RD_STORE;
				end
				RD_STORE: if (!sd_ack) begin  // Sector end
					sd_lba       <= sd_lba + 1'b1;
					sectors_left <= sectors_left - 1'b1;
					sec_base     <= sec_base + SECTOR_WORDS;
					wr_word      <= sec_base + SECTOR_WORDS;  // Realign after a short sector
					state        <= RD_NEXT;
				end
				default: begin
					if (sectors_left == 8'd0) begin
						fetch.loaded <= 1'b1;
						state        <= RD_IDLE;
					end else begin
						sd_rd <= 1'b1;  // sd_ack already low here
						state <= RD_REQ;
					end
				end
			endcase
		end
	end

endmodule

//--- hdl/scsi_target.sv
module scsi_target
	import cd_bus_pkg::*, cd_regs_pkg::*;
#(
	parameter int SECTOR_BYTES = 2048,
	parameter int BUF_BYTES    = 16384
) (
	input logic       CLOCK,
	input logic       RESET,
	cd_link_if.target link,
	cd_fetch_if.ctrl  fetch
);
	localparam int AW  = $clog2(BUF_BYTES);
	localparam int SBW = $clog2(SECTOR_BYTES);
	localparam int XW  = 8 + SBW;  // Holds 255 sectors of bytes
	localparam int PW  = $clog2(CMD_BUF_DEPTH);

	// Per-phase handshake step
	typedef enum logic [1:0] {HS_WAIT_ACK, HS_WAIT_REL, HS_DECODE, HS_FETCH} hs_e;

	cd_phase_e  phase;
	hs_e        hs;
	logic       req;
	cd_byte_t   cmd_buf [CMD_BUF_DEPTH];
	logic [PW-1:0] cmd_pos;
	logic [PW-1:0] pkt_len;
	cd_opcode_e opcode;
	logic [XW-1:0] byte_pos;
	logic       xfer_end;
	cd_lines_t  lines_c;

	assign opcode   = cd_opcode_e'(cmd_buf[0]);
	assign xfer_end = (byte_pos == {fetch.count, {SBW{1'b0}}});
	assign fetch.rd_pos = byte_pos[AW-1:0];  // Wraps if count overfills the buffer

	always_comb begin
		case (opcode)
			NEC_AUDIO_START, NEC_AUDIO_STOP, NEC_PAUSE,
			NEC_GET_SUBQ, NEC_GET_DIR: pkt_len = PW'(10);
			END_OF_LIST, SELECT_ID:    pkt_len = PW'(1);
			default:                   pkt_len = PW'(6);  // Group 0, unknown too
		endcase
	end

	always_comb begin
		lines_c.bsy = (phase != BUS_FREE);
		lines_c.req = req;
		lines_c.msg = (phase == MESSAGE_IN);
		lines_c.cd  = (phase == COMMAND) || (phase == STATUS) || (phase == MESSAGE_IN);
		lines_c.io  = (phase == DATA_IN) || (phase == STATUS) || (phase == MESSAGE_IN);
	end
	assign link.lines = lines_c;

	always_comb begin
		case (phase)
			DATA_IN:            link.bus_byte = fetch.rd_data;
			STATUS, MESSAGE_IN: link.bus_byte = 8'h00;  // Good status, command complete
			default:            link.bus_byte = link.cmd_byte;
		endcase
	end

	// Packet capture and READ(6) arguments
	always_ff @(posedge CLOCK) begin
		if (phase == COMMAND && hs == HS_WAIT_ACK && link.ack)
			cmd_buf[cmd_pos] <= link.cmd_byte;
		if (phase == COMMAND && hs == HS_DECODE) begin
			fetch.first_lba <= {11'd0, cmd_buf[1][4:0], cmd_buf[2], cmd_buf[3]};
			fetch.count     <= cmd_buf[4];
		end
	end

	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			phase          <= BUS_FREE;
			hs             <= HS_WAIT_ACK;
			req            <= 1'b0;
			cmd_pos        <= '0;
			byte_pos       <= '0;
			link.selected  <= 1'b0;
			link.set_ready <= 1'b0;
			link.clr_ready <= 1'b0;
			link.set_done  <= 1'b0;
			link.clr_done  <= 1'b0;
			fetch.start    <= 1'b0;
		end else begin
			link.set_ready <= 1'b0;
			link.clr_ready <= 1'b0;
			link.set_done  <= 1'b0;
			link.clr_done  <= 1'b0;
			fetch.start    <= 1'b0;
			if (link.drive_rst || link.desel) begin
				if (phase != BUS_FREE)
					link.clr_done <= 1'b1;
				phase         <= BUS_FREE;
				hs            <= HS_WAIT_ACK;
				req           <= 1'b0;
				link.selected <= 1'b0;
			end else if (link.sel) begin
				phase         <= COMMAND;
				hs            <= HS_WAIT_ACK;
				req           <= 1'b1;
				cmd_pos       <= '0;
				link.selected <= 1'b1;
			end else if (phase != BUS_FREE) begin
				case (hs)
					HS_WAIT_ACK: if (link.ack) begin
						req <= 1'b0;  // Byte taken or presented
						hs  <= HS_WAIT_REL;
						if (phase == COMMAND)
							cmd_pos <= cmd_pos + 1'b1;
						if (phase == DATA_IN)
							byte_pos <= byte_pos + 1'b1;
					end
					HS_WAIT_REL: if (!link.ack) begin
						hs  <= HS_WAIT_ACK;
						req <= 1'b1;
						case (phase)
							COMMAND: if (cmd_pos >= pkt_len) begin
								req <= 1'b0;
								hs  <= HS_DECODE;
							end
							DATA_IN: if (xfer_end) begin
								link.clr_ready <= 1'b1;
								link.set_done  <= 1'b1;
								phase          <= STATUS;
							end
							STATUS: phase <= MESSAGE_IN;
							default: begin  // Message sent, release the bus
								req           <= 1'b0;
								phase         <= BUS_FREE;
								link.selected <= 1'b0;
								link.clr_done <= 1'b1;
							end
						endcase
					end
					HS_DECODE: begin
						hs  <= HS_WAIT_ACK;
						req <= 1'b1;
						phase <= STATUS;
						case (opcode)
							READ6: if (cmd_buf[4] != 8'd0) begin
								req         <= 1'b0;
								phase       <= COMMAND;
								hs          <= HS_FETCH;
								fetch.start <= 1'b1;
							end
							NEC_AUDIO_START, NEC_AUDIO_STOP, NEC_PAUSE,
							NEC_GET_SUBQ, NEC_GET_DIR: link.set_done <= 1'b1;
							default: ;
						endcase
					end
					default: if (fetch.loaded) begin  // HS_FETCH
						link.set_ready <= 1'b1;
						phase          <= DATA_IN;
						byte_pos       <= '0;
						req            <= 1'b1;
						hs             <= HS_WAIT_ACK;
					end
				endcase
			end
		end
	end

endmodule

//--- hdl/cdc_regs.sv
module cdc_regs
	import cd_bus_pkg::*, cd_regs_pkg::*;
(
	input  logic     CLOCK,
	input  logic     RESET,
	input  logic     CS_N,
	input  logic     RD_N,
	input  logic     WR_N,
	input  cd_byte_t ADDR,
	input  cd_byte_t DIN,
	output cd_byte_t DOUT,
	output logic     IRQ2_ASSERT,
	cd_link_if.regs  link
);
	logic     wr_n_s1;
	logic     wr_n_s2;
	logic     wr_n_s3;   // Edge detect
	logic     wr_stb;
	cd_reg_e  reg_sel;
	cd_byte_t int_mask;
	cd_byte_t cd_reset;
	logic     ready_flag;
	logic     done_flag;
	cd_byte_t irq_flags;
	cd_byte_t read_val;

	assign reg_sel = cd_reg_e'(ADDR);
	assign wr_stb  = wr_n_s3 && !wr_n_s2 && !CS_N;  // Falling WR_N, 3 cycles late

	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			wr_n_s1 <= 1'b1;
			wr_n_s2 <= 1'b1;
			wr_n_s3 <= 1'b1;
		end else begin
			wr_n_s1 <= WR_N;
			wr_n_s2 <= wr_n_s1;
			wr_n_s3 <= wr_n_s2;
		end
	end

	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			int_mask       <= '0;
			cd_reset       <= 8'h02;  // Drive starts held in reset
			ready_flag     <= 1'b0;
			done_flag      <= 1'b0;
			link.sel       <= 1'b0;
			link.desel     <= 1'b0;
		end else begin
			link.sel   <= 1'b0;
			link.desel <= 1'b0;
			if (wr_stb) begin
				case (reg_sel)
					CDC_STAT: begin
						ready_flag <= 1'b0;  // Any write acks the transfer IRQs
						done_flag  <= 1'b0;
						link.sel   <= (DIN == SELECT_ID);
					end
					CDC_CMD:  link.desel <= (DIN == SELECT_ID);
					INT_MASK: int_mask <= DIN;
					CD_RESET: cd_reset <= DIN;
					default: ;
				endcase
			end
			// Target events win over a CPU clear in the same cycle
			if (link.set_ready) ready_flag <= 1'b1;
			if (link.clr_ready) ready_flag <= 1'b0;
			if (link.set_done)  done_flag  <= 1'b1;
			if (link.clr_done)  done_flag  <= 1'b0;
			if (link.drive_rst) begin
				ready_flag <= 1'b0;
				done_flag  <= 1'b0;
				int_mask   <= '0;
			end
		end
	end

	always_ff @(posedge CLOCK) begin
		if (wr_stb && reg_sel == CDC_CMD)
			link.cmd_byte <= DIN;  // Packet byte, valid before ACK
	end

	assign link.ack       = int_mask[7];
	assign link.drive_rst = cd_reset[1];

	always_comb begin
		irq_flags                = '0;
		irq_flags[IRQ_READY_BIT] = ready_flag;
		irq_flags[IRQ_DONE_BIT]  = done_flag;
	end

	assign IRQ2_ASSERT = |(int_mask & irq_flags & IRQ_ENABLE_MASK);

	always_comb begin
		case (reg_sel)
			CDC_STAT:  read_val = {link.lines, link.selected ? DRIVE_ID_BITS : 3'b000};
			CDC_CMD:   read_val = link.bus_byte;
			INT_MASK:  read_val = int_mask;
			IRQ_FLAGS: read_val = irq_flags;
			CD_RESET:  read_val = cd_reset;
			ID_C1:     read_val = ID_BYTE_C1;
			ID_C2:     read_val = ID_BYTE_C2;
			ID_C3:     read_val = ID_BYTE_C3;
			ID_C4:     read_val = ID_BYTE_C4;
			ID_C5:     read_val = ID_BYTE_C5;
			ID_C6:     read_val = ID_BYTE_C6;
			ID_C7:     read_val = ID_BYTE_C7;
			default:   read_val = 8'hFF;  // Open bus
		endcase
	end

	// Idle bus floats high
	assign DOUT = (!CS_N && !RD_N) ? read_val : 8'hFF;

endmodule

//--- hdl/cd_link_if.sv
// Register block to target
interface cd_link_if import cd_bus_pkg::*, cd_regs_pkg::*; ();
	logic      sel;        // Strobe
	logic      desel;      // Strobe
	cd_byte_t  cmd_byte;   // Last CDC_CMD write
	logic      ack;
	logic      drive_rst;
	cd_lines_t lines;
	logic      selected;
	cd_byte_t  bus_byte;   // CDC_CMD read value
	logic      set_ready;
	logic      clr_ready;
	logic      set_done;
	logic      clr_done;

	modport regs (output sel, desel, cmd_byte, ack, drive_rst,
		input lines, selected, bus_byte, set_ready, clr_ready, set_done, clr_done);
	modport target (input sel, desel, cmd_byte, ack, drive_rst,
		output lines, selected, bus_byte, set_ready, clr_ready, set_done, clr_done);
endinterface

// Target to sector reader
interface cd_fetch_if import cd_bus_pkg::*, cd_regs_pkg::*; #(
	parameter int BUF_BYTES = 16384
) ();
	logic                         start;
	cd_lba_t                      first_lba;
	logic [7:0]                   count;    // Sectors
	logic [$clog2(BUF_BYTES)-1:0] rd_pos;
	logic                         loaded;   // Strobe, all sectors stored
	cd_byte_t                     rd_data;  // One cycle after rd_pos

	modport ctrl (output start, first_lba, count, rd_pos, input loaded, rd_data);
	modport reader (input start, first_lba, count, rd_pos, output loaded, rd_data);
endinterface

//--- hdl/cd_regs_pkg.sv
package cd_regs_pkg;

	typedef logic [7:0] cd_byte_t;

	// CPU register map, low address byte
	typedef enum logic [7:0] {
		CDC_STAT  = 8'h00,
		CDC_CMD   = 8'h01,
		INT_MASK  = 8'h02,  // Bit 7 doubles as ACK
		IRQ_FLAGS = 8'h03,
		CD_RESET  = 8'h04,  // Bit 1 holds the drive in reset
		ID_C1     = 8'hC1,
		ID_C2     = 8'hC2,
		ID_C3     = 8'hC3,
		ID_C4     = 8'hC4,
		ID_C5     = 8'hC5,
		ID_C6     = 8'hC6,
		ID_C7     = 8'hC7
	} cd_reg_e;

	localparam int IRQ_READY_BIT = 6;
	localparam int IRQ_DONE_BIT  = 5;

	localparam cd_byte_t IRQ_ENABLE_MASK = 8'h7C;
	localparam logic [2:0] DRIVE_ID_BITS = 3'b001;  // SCSI ID 0

	// System card identification, Japanese card
	localparam cd_byte_t ID_BYTE_C1 = 8'hAA;
	localparam cd_byte_t ID_BYTE_C2 = 8'h55;
	localparam cd_byte_t ID_BYTE_C3 = 8'h00;
	localparam cd_byte_t ID_BYTE_C4 = 8'hFF;  // Not decoded on the card
	localparam cd_byte_t ID_BYTE_C5 = 8'hAA;
	localparam cd_byte_t ID_BYTE_C6 = 8'h55;
	localparam cd_byte_t ID_BYTE_C7 = 8'h03;

endpackage

//--- hdl/cd_bus_pkg.sv
package cd_bus_pkg;

	// Bus phases seen by the initiator
	typedef enum logic [2:0] {
		BUS_FREE,
		COMMAND,
		DATA_IN,
		STATUS,
		MESSAGE_IN
	} cd_phase_e;

	// First packet byte
	typedef enum logic [7:0] {
		TEST_UNIT_READY = 8'h00,
		READ6           = 8'h08,
		NEC_AUDIO_START = 8'hD8,
		NEC_AUDIO_STOP  = 8'hD9,
		NEC_PAUSE       = 8'hDA,
		NEC_GET_SUBQ    = 8'hDD,
		NEC_GET_DIR     = 8'hDE,
		END_OF_LIST     = 8'hFF,
		SELECT_ID       = 8'h81  // Initiator and drive IDs OR'ed
	} cd_opcode_e;

	// Target-driven lines, same order as CDC_STAT [7:3]
	typedef struct packed {
		logic bsy;
		logic req;
		logic msg;
		logic cd;
		logic io;
	} cd_lines_t;

	typedef logic [31:0] cd_lba_t;

	localparam int CMD_BUF_DEPTH = 16;  // Longest packet is 10

endpackage
